/* rtl/motor_defs.svh */
`ifndef MOTOR_DEFS_SVH
`define MOTOR_DEFS_SVH

// cycles a raw key level has to hold before the debouncer believes it
// kept short here so simulation stays quick
// the board build runs this at 2500
`define MOTOR_DEBOUNCE_COUNTS 16

// clock cycles per serial bit on the motor controller line
// one frame of four bytes takes 40 bit times
`define MOTOR_CLKS_PER_BIT 8

// first byte of every command frame
// the controller resyncs on the set top bit
`define MOTOR_FRAME_HEADER 8'h80

// push-buttons on the board
// key 0 forward, key 1 reverse, key 2 stop, key 3 spare
`define MOTOR_NUM_KEYS 4

`endif

/* rtl/motor_pkg.sv */
package motor_pkg;

	// driving direction, same encoding as the LED readout on the board
	typedef enum logic [1:0] {
		DIR_FORWARD = 2'd0,
		DIR_REVERSE = 2'd1,
		DIR_STOP    = 2'd2
	} direction_t;

	// command byte understood by the motor controller
	typedef enum logic [7:0] {
		OP_FORWARD = 8'd0,
		OP_REVERSE = 8'd1,
		OP_STOP    = 8'd2
	} motor_op_t;

	// frame sequencer, one state per byte still to hand over
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_HEADER,
		SEQ_OPCODE,
		SEQ_SPEED,
		SEQ_CHECKSUM
	} seq_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} uart_state_t;

	typedef struct packed {
		direction_t dir;
		logic [2:0] speed;  // speed minus one
	} drive_cmd_t;

	// fwd sits in bit 0 so the struct lines up with the key bus
	typedef struct packed {
		logic spare;
		logic stop;
		logic rev;
		logic fwd;
	} key_press_t;

endpackage

/* rtl/key_conditioner.sv */
`timescale 1ns/1ps
`include "motor_defs.svh"

module key_conditioner (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`MOTOR_NUM_KEYS-1:0] keys,     // raw buttons, active low
	output motor_pkg::key_press_t      presses
);

	import motor_pkg::*;

	localparam int CNT_W = $clog2(`MOTOR_DEBOUNCE_COUNTS + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MOTOR_DEBOUNCE_COUNTS - 1);

	logic [`MOTOR_NUM_KEYS-1:0] press_q;

	genvar i;
	generate
		for (i = 0; i < `MOTOR_NUM_KEYS; i++) begin : g_key
			logic [CNT_W-1:0] stable_cnt;  // cycles the raw level has differed
			logic             level;       // debounced, 1 means pressed
			logic             press;
			logic             pressed_raw;

			assign pressed_raw = ~keys[i];

			always_ff @(posedge clk) begin
				if (reset) begin
					stable_cnt <= '0;
					level      <= 1'b0;
					press      <= 1'b0;
				end else begin
					press <= 1'b0;
					if (pressed_raw == level) begin
						stable_cnt <= '0;  // bounce back, start over
					end else if (stable_cnt == CNT_LAST) begin
						stable_cnt <= '0;
						level      <= pressed_raw;
						// edge only on the way into pressed
						press      <= pressed_raw;
					end else begin
						stable_cnt <= stable_cnt + 1'b1;
					end
				end
			end

			assign press_q[i] = press;
		end
	endgenerate

	// releases need the same stable time, so a held key fires once
	assign presses = key_press_t'(press_q);

endmodule

/* rtl/speed_sync.sv */
`timescale 1ns/1ps

module speed_sync (
	input  logic       clk,
	input  logic       reset,
	input  logic       pitch_valid,  // from the pitch detector clock
	input  logic [2:0] pitch_code,   // held stable around the valid pulse
	output logic [2:0] speed_code
);

	logic       valid_meta;
	logic       valid_sync;
	logic       valid_prev;
	logic       valid_rise;
	logic       capture_stb;
	logic [2:0] code_capture;

	assign valid_rise = valid_sync & ~valid_prev;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_meta  <= 1'b0;
			valid_sync  <= 1'b0;
			valid_prev  <= 1'b0;
			capture_stb <= 1'b0;
			speed_code  <= '0;
		end else begin
			valid_meta  <= pitch_valid;
			valid_sync  <= valid_meta;
			valid_prev  <= valid_sync;
			capture_stb <= valid_rise;
			if (capture_stb)
				speed_code <= code_capture;  // code 0 still means speed 1
		end
	end

	// code bus is only looked at once valid has settled on this side
	always_ff @(posedge clk) begin
		if (valid_rise)
			code_capture <= pitch_code;
	end

endmodule

/* rtl/direction_fsm.sv */
`timescale 1ns/1ps

module direction_fsm (
	input  logic                  clk,
	input  logic                  reset,
	input  motor_pkg::key_press_t presses,
	output motor_pkg::direction_t dir
);

	import motor_pkg::*;

	direction_t dir_next;

	// stop beats reverse beats forward when keys land together
	always_comb begin
		dir_next = dir;
		if (presses.stop) begin
			dir_next = DIR_STOP;
		end else if (presses.rev) begin
			dir_next = DIR_REVERSE;
		end else if (presses.fwd) begin
			dir_next = DIR_FORWARD;
		end
		// spare key has no job yet
	end

	always_ff @(posedge clk) begin
		if (reset)
			dir <= DIR_STOP;  // robot parked out of reset
		else
			dir <= dir_next;
	end

endmodule

/* rtl/drive_command_seq.sv */
`timescale 1ns/1ps
`include "motor_defs.svh"

module drive_command_seq (
	input  logic                  clk,
	input  logic                  reset,
	input  motor_pkg::drive_cmd_t cmd,
	input  logic                  tx_busy,
	output logic                  tx_start,
	output logic [7:0]            tx_byte
);

	import motor_pkg::*;

	seq_state_t state;
	seq_state_t state_next;
	drive_cmd_t last_sent;   // what the controller was last told
	motor_op_t  opcode;
	logic [7:0] speed_byte;
	logic [7:0] byte_sum;
	logic [7:0] checksum;

	always_comb begin
		case (last_sent.dir)
			DIR_FORWARD: opcode = OP_FORWARD;
			DIR_REVERSE: opcode = OP_REVERSE;
			default:     opcode = OP_STOP;
		endcase
	end

	assign speed_byte = {5'd0, last_sent.speed} + 8'd1;  // 1 to 8 on the wire
	assign byte_sum   = `MOTOR_FRAME_HEADER + opcode + speed_byte;
	assign checksum   = {1'b0, byte_sum[6:0]};

	// a byte is offered whenever one is pending and the UART can take it
	assign tx_start = (state != SEQ_IDLE) && !tx_busy;

	always_comb begin
		case (state)
			SEQ_HEADER:   tx_byte = `MOTOR_FRAME_HEADER;
			SEQ_OPCODE:   tx_byte = opcode;
			SEQ_SPEED:    tx_byte = speed_byte;
			SEQ_CHECKSUM: tx_byte = checksum;
			default:      tx_byte = 8'h00;
		endcase
	end

	always_comb begin
		state_next = state;
		case (state)
			SEQ_IDLE:     if (cmd != last_sent) state_next = SEQ_HEADER;
			SEQ_HEADER:   if (tx_start) state_next = SEQ_OPCODE;
			SEQ_OPCODE:   if (tx_start) state_next = SEQ_SPEED;
			SEQ_SPEED:    if (tx_start) state_next = SEQ_CHECKSUM;
			SEQ_CHECKSUM: if (tx_start) state_next = SEQ_IDLE;
			default:      state_next = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= SEQ_IDLE;
			last_sent <= '{dir: DIR_STOP, speed: 3'd0};  // matches the parked robot
		end else begin
			state <= state_next;
			// snapshot taken with the header so the rest of the frame agrees
			if (state == SEQ_HEADER && tx_start)
				last_sent <= cmd;
		end
	end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps
`include "motor_defs.svh"

module uart_tx (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       tx_busy,
	output logic       line
);

	import motor_pkg::*;

	localparam int TMR_W = $clog2(`MOTOR_CLKS_PER_BIT + 1);
	localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(`MOTOR_CLKS_PER_BIT - 1);

	uart_state_t      state;
	logic [TMR_W-1:0] bit_timer;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_q;
	logic             bit_done;
	logic             load;

	assign bit_done = (bit_timer == TMR_LAST);

	// free again in the last stop cycle so bytes run back to back
	assign tx_busy = (state != TX_IDLE) && !(state == TX_STOP && bit_done);
	assign load    = tx_start && !tx_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= TX_IDLE;
			bit_timer <= '0;
			bit_idx   <= '0;
			line      <= 1'b1;  // idle high
		end else begin
			if (state == TX_IDLE || bit_done)
				bit_timer <= '0;
			else
				bit_timer <= bit_timer + 1'b1;

			case (state)
				TX_IDLE: begin
					if (load) begin
						state <= TX_START;
						line  <= 1'b0;
					end
				end
				TX_START: begin
					if (bit_done) begin
						state <= TX_DATA;
						line  <= shift_q[0];  // lsb first
					end
				end
				TX_DATA: begin
					if (bit_done) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= TX_STOP;
							line  <= 1'b1;
						end else begin
							line <= shift_q[1];
						end
					end
				end
				TX_STOP: begin
					if (bit_done) begin
						if (load) begin
							state <= TX_START;
							line  <= 1'b0;
						end else begin
							state <= TX_IDLE;
						end
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			shift_q <= tx_byte;
		else if (state == TX_DATA && bit_done)
			shift_q <= shift_q >> 1;
	end

endmodule

/* rtl/motor_drive_top.sv */
`timescale 1ns/1ps
`include "motor_defs.svh"

module motor_drive_top (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`MOTOR_NUM_KEYS-1:0] keys,         // active low
	input  logic                       pitch_valid,  // pitch detector domain
	input  logic [2:0]                 pitch_code,
	output motor_pkg::direction_t      direction,    // also drives the LEDs
	output logic                       uart_out
);

	import motor_pkg::*;

	key_press_t presses;
	logic [2:0] speed_code;
	drive_cmd_t cmd;
	logic       tx_start;
	logic [7:0] tx_byte;
	logic       tx_busy;

	key_conditioner key_conditioner_i (
		.clk     (clk),
		.reset   (reset),
		.keys    (keys),
		.presses (presses)
	);

	direction_fsm direction_fsm_i (
		.clk     (clk),
		.reset   (reset),
		.presses (presses),
		.dir     (direction)
	);

	speed_sync speed_sync_i (
		.clk         (clk),
		.reset       (reset),
		.pitch_valid (pitch_valid),
		.pitch_code  (pitch_code),
		.speed_code  (speed_code)
	);

	assign cmd = '{dir: direction, speed: speed_code};

	drive_command_seq drive_command_seq_i (
		.clk      (clk),
		.reset    (reset),
		.cmd      (cmd),
		.tx_busy  (tx_busy),
		.tx_start (tx_start),
		.tx_byte  (tx_byte)
	);

	uart_tx uart_tx_i (
		.clk      (clk),
		.reset    (reset),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_busy  (tx_busy),
		.line     (uart_out)
	);

endmodule

/* dv/motor_drive_tb.sv */
`timescale 1ns/1ps
`include "motor_defs.svh"

module motor_drive_tb;

	import motor_pkg::*;

	localparam int DEB = `MOTOR_DEBOUNCE_COUNTS;
	localparam int CPB = `MOTOR_CLKS_PER_BIT;
	localparam int FRAME_CYCLES = 40 * CPB;
	localparam int SETTLE_CYCLES = 2 * FRAME_CYCLES + 2 * CPB;
	localparam int N_PHASES = 30;
	// one phase is at most a long hold, a release and a settle window
	localparam int TIMEOUT_CYCLES = (N_PHASES + 2) * (12 * DEB + SETTLE_CYCLES);

	logic       clk;
	logic       reset;
	logic [3:0] keys;
	logic       pitch_valid;
	logic [2:0] pitch_code;
	direction_t direction;
	logic       uart_out;

	int         seed;
	int         cycle_count;
	direction_t exp_dir;         // model state
	logic [7:0] exp_speed;
	logic [2:0] last_code;
	logic [7:0] frame_bytes [4];
	int         byte_idx;
	time        last_header_time;
	logic [7:0] last_op;         // taken from the last decoded frame
	logic [7:0] last_speed;

	motor_drive_top motor_drive_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("ERRORS FOUND");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic report_mismatch(input string msg);
		$display("Fail at %0t: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at the first mismatch");
	endtask

	function automatic int random_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	// direction has to sit at the model value the whole time
	task automatic hold_checked(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (direction == exp_dir)
				else report_mismatch($sformatf("direction %0d, model %0d", direction, exp_dir));
		end
	endtask

	task automatic press_key(input int k, input int hold);
		@(posedge clk);
		keys[k] <= 1'b0;
		case (k)
			0:       exp_dir = DIR_FORWARD;
			1:       exp_dir = DIR_REVERSE;
			2:       exp_dir = DIR_STOP;
			default: ;  // spare key leaves the direction alone
		endcase
		repeat (DEB + 4) @(negedge clk);
		assert (direction == exp_dir)
			else report_mismatch($sformatf("direction %0d after key %0d", direction, k));
		hold_checked(hold);
		@(posedge clk);
		keys[k] <= 1'b1;
		hold_checked(DEB + 4);
	endtask

	// low bursts shorter than the debounce time
	task automatic bounce_key(input int k);
		int bursts;
		bursts = 1 + random_below(5);
		repeat (bursts) begin
			@(posedge clk);
			keys[k] <= 1'b0;
			hold_checked(1 + random_below(DEB - 1));
			@(posedge clk);
			keys[k] <= 1'b1;
			hold_checked(1 + random_below(4));
		end
		hold_checked(DEB + 4);
	endtask

	task automatic update_pitch(input logic [2:0] code);
		@(posedge clk);
		pitch_code <= code;
		@(posedge clk);
		pitch_valid <= 1'b1;
		repeat (6) @(posedge clk);
		pitch_valid <= 1'b0;
		exp_speed = {5'd0, code} + 8'd1;
		last_code = code;
	endtask

	task automatic settle_and_check();
		logic [7:0] exp_op;
		exp_op = (exp_dir == DIR_FORWARD) ? 8'd0 : (exp_dir == DIR_REVERSE) ? 8'd1 : 8'd2;
		hold_checked(SETTLE_CYCLES);
		assert (byte_idx == 0) else report_mismatch("line still busy after the settle window");
		assert (last_op == exp_op && last_speed == exp_speed)
			else report_mismatch($sformatf("frame op %0d speed %0d, model op %0d speed %0d",
				last_op, last_speed, exp_op, exp_speed));
	endtask

	// same direction, spare key or same pitch again
	task automatic repeat_phase();
		int  pick;
		time quiet_start;
		quiet_start = $time;
		pick = random_below(3);
		if (pick == 0)
			update_pitch(last_code);
		else if (pick == 1)
			press_key(3, 4);
		else
			press_key((exp_dir == DIR_FORWARD) ? 0 : (exp_dir == DIR_REVERSE) ? 1 : 2, 4);
		settle_and_check();
		assert (last_header_time < quiet_start)
			else report_mismatch("header sent for an unchanged command");
	endtask

	initial begin : line_decoder
		logic [7:0] rx;
		logic [7:0] sum;
		byte_idx = 0;
		last_header_time = 0;
		last_op = 8'd2;  // stop at speed 1 out of reset
		last_speed = 8'd1;
		@(negedge reset);
		forever begin
			@(negedge clk);
			if (uart_out == 1'b0) begin
				if (byte_idx == 0) begin
					last_header_time = $time;
				end
				repeat (CPB / 2) @(negedge clk);  // middle of the start bit
				assert (uart_out == 1'b0) else report_mismatch("start bit too short");
				for (int b = 0; b < 8; b++) begin
					repeat (CPB) @(negedge clk);
					rx[b] = uart_out;  // lsb first
				end
				repeat (CPB) @(negedge clk);
				assert (uart_out == 1'b1) else report_mismatch("stop bit low");
				frame_bytes[byte_idx] = rx;
				byte_idx++;
				if (byte_idx == 4) begin
					sum = frame_bytes[0] + frame_bytes[1] + frame_bytes[2];
					assert (frame_bytes[0] == `MOTOR_FRAME_HEADER)
						else report_mismatch($sformatf("header %h", frame_bytes[0]));
					assert (frame_bytes[1] <= 8'd2)
						else report_mismatch($sformatf("opcode %h", frame_bytes[1]));
					assert (frame_bytes[2] >= 8'd1 && frame_bytes[2] <= 8'd8)
						else report_mismatch($sformatf("speed byte %h", frame_bytes[2]));
					assert (frame_bytes[3] == {1'b0, sum[6:0]})
						else report_mismatch($sformatf("checksum %h", frame_bytes[3]));
					last_op = frame_bytes[1];
					last_speed = frame_bytes[2];
					byte_idx = 0;
				end
			end
		end
	end

	initial begin
		int choice;
		seed = 32'hdec;
		keys <= '1;
		pitch_valid <= 1'b0;
		pitch_code <= 3'd0;
		reset <= 1'b1;
		exp_dir = DIR_STOP;
		exp_speed = 8'd1;
		last_code = 3'd0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		repeat (FRAME_CYCLES) begin
			@(negedge clk);
			assert (uart_out == 1'b1) else report_mismatch("uart_out left idle after reset");
		end
		for (int p = 0; p < N_PHASES; p++) begin
			if (p % 5 == 4) begin
				repeat_phase();
			end else begin
				choice = random_below(8);
				case (choice)
					0, 1, 2: press_key(random_below(4), 1 + random_below(8));
					3:       press_key(random_below(4), 6 * DEB);  // long hold
					4:       bounce_key(random_below(4));
					default: update_pitch(3'(random_below(8)));
				endcase
				settle_and_check();
			end
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* motor_drive_top.f */
+incdir+rtl
rtl/motor_pkg.sv
rtl/key_conditioner.sv
rtl/speed_sync.sv
rtl/direction_fsm.sv
rtl/drive_command_seq.sv
rtl/uart_tx.sv
rtl/motor_drive_top.sv
dv/motor_drive_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module motor_drive_tb \
	-f motor_drive_top.f -o motor_drive_sim
./obj_dir/motor_drive_sim 2>&1 | tee sim.log

if grep -q "NO ERRORS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
